//--- pong_cfg.svh
`ifndef PONG_CFG_SVH
`define PONG_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Playing field
//////////////////////////////////////////////////////////////////////
`define PONG_FIELD_W        64
`define PONG_FIELD_H        18

// Paddle centre limits
`define PONG_PADDLE_HOME    9
`define PONG_PADDLE_MIN     2
`define PONG_PADDLE_MAX     16

// Columns where a paddle can return the ball
`define PONG_LEFT_HIT_X     2
`define PONG_RIGHT_HIT_X    61
`define PONG_LEFT_SERVE_X   3
`define PONG_RIGHT_SERVE_X  60
`define PONG_MAX_SPEED      5

//////////////////////////////////////////////////////////////////////
// Key codes and APB register map
//////////////////////////////////////////////////////////////////////
`define PONG_KEY_LEFT_UP    8'h77
`define PONG_KEY_LEFT_DOWN  8'h73
`define PONG_KEY_RIGHT_UP   8'h69
`define PONG_KEY_RIGHT_DOWN 8'h6B
`define PONG_KEY_LAUNCH     8'h20
`define PONG_REG_KEY        4'h0
`define PONG_REG_TICK       4'h4
`define PONG_REG_POS        4'h8
`define PONG_REG_STATE      4'hC

`endif

//--- pongPkg.sv
package pongPkg;

	//////////////////////////////////////////////////////////////////////
	// Commands and ball modes
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		cmdLeftUp,
		cmdLeftDown,
		cmdRightUp,
		cmdRightDown,
		cmdLaunch,
		cmdTick
	} pongCmd;

	// Held modes keep the ball stuck to a paddle until served
	typedef enum logic [1:0] {
		ballFlying,
		ballHeldLeft,
		ballHeldRight
	} ballMode;

	//////////////////////////////////////////////////////////////////////
	// Items passed between stages
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic   valid;
		pongCmd cmd;
	} cmdItem;

	typedef struct packed {
		logic       valid;
		pongCmd     cmd;
		logic [7:0] leftPos;
		logic [7:0] rightPos;
	} paddleItem;

	typedef struct packed {
		logic       valid;
		logic       pointLeft;
		logic       pointRight;
		logic [7:0] ballX;
		logic [7:0] ballY;
		ballMode    mode;
		logic [2:0] speed;
		logic [7:0] leftPos;
		logic [7:0] rightPos;
	} ballItem;

	// Snapshot seen by the register port
	typedef struct packed {
		logic       done;
		logic [3:0] scoreLeft;
		logic [3:0] scoreRight;
		logic [7:0] ballX;
		logic [7:0] ballY;
		ballMode    mode;
		logic [2:0] speed;
		logic [7:0] leftPos;
		logic [7:0] rightPos;
	} pongStatus;

endpackage

//--- pongApbPort.sv
`timescale 1ns/1ns
`include "pong_cfg.svh"

module pongApbPort (
	input  logic               CLK,
	input  logic               resetBall,
	input  logic               PSEL,
	input  logic               PENABLE,
	input  logic               PWRITE,
	input  logic [3:0]         PADDR,
	input  logic [31:0]        PWDATA,
	output logic               PREADY,
	output logic [31:0]        PRDATA,
	output logic               PSLVERR,
	output pongPkg::cmdItem    cmdOut,
	input  logic               cmdReady,
	input  pongPkg::pongStatus status
);
	import pongPkg::*;

	logic       setupPhase;
	logic       accessPhase;
	logic       keyKnown;
	pongCmd     keyCmd;
	pongCmd     issueCmd;
	logic       isCmd;
	logic       badAddr;
	logic       issue;
	logic [2:0] inFlight;
	logic       busy;

	assign setupPhase = PSEL && !PENABLE;
	assign accessPhase = PSEL && PENABLE;

	// Key code lookup
	always_comb begin
		keyKnown = 1'b1;
		keyCmd = cmdTick;
		case (PWDATA[7:0])
			`PONG_KEY_LEFT_UP:    keyCmd = cmdLeftUp;
			`PONG_KEY_LEFT_DOWN:  keyCmd = cmdLeftDown;
			`PONG_KEY_RIGHT_UP:   keyCmd = cmdRightUp;
			`PONG_KEY_RIGHT_DOWN: keyCmd = cmdRightDown;
			`PONG_KEY_LAUNCH:     keyCmd = cmdLaunch;
			default:              keyKnown = 1'b0;
		endcase
	end

	// Address decode; unknown keys fall through as a plain completed write
	always_comb begin
		isCmd = 1'b0;
		badAddr = 1'b0;
		issueCmd = keyCmd;
		if (PWRITE) begin
			case (PADDR)
				`PONG_REG_KEY:  isCmd = keyKnown;
				`PONG_REG_TICK: begin
					isCmd = 1'b1;
					issueCmd = cmdTick;
				end
				default:        badAddr = 1'b1;
			endcase
		end else begin
			badAddr = (PADDR != `PONG_REG_POS) && (PADDR != `PONG_REG_STATE);
		end
	end

	// Command waits in the access phase until the paddle stage takes it
	assign issue = accessPhase && isCmd && cmdReady;
	assign cmdOut = '{valid: accessPhase && isCmd, cmd: issueCmd};
	assign PREADY = accessPhase && (!isCmd || cmdReady);
	assign PSLVERR = accessPhase && badAddr;

	//////////////////////////////////////////////////////////////////////
	// Commands in flight
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (resetBall) begin
			inFlight <= '0;
		end else if (issue && !status.done) begin
			inFlight <= inFlight + 3'd1;
		end else if (!issue && status.done) begin
			inFlight <= inFlight - 3'd1;
		end
	end

	assign busy = (inFlight != 3'd0);

	// Read data captured in setup so the access phase needs no wait state
	always_ff @(posedge CLK) begin
		if (setupPhase && !PWRITE) begin
			if (PADDR == `PONG_REG_POS) begin
				PRDATA <= {status.rightPos, status.leftPos, status.ballY, status.ballX};
			end else if (PADDR == `PONG_REG_STATE) begin
				PRDATA <= {15'd0, busy, 1'b0, status.speed, 2'b00, status.mode,
					status.scoreRight, status.scoreLeft};
			end else begin
				PRDATA <= '0;
			end
		end
	end

endmodule

//--- paddleStage.sv
`timescale 1ns/1ns
`include "pong_cfg.svh"

module paddleStage (
	input  logic               CLK,
	input  logic               resetBall,
	input  pongPkg::cmdItem    cmdIn,
	output logic               cmdReady,
	output pongPkg::paddleItem paddleOut,
	input  logic               paddleReady
);
	import pongPkg::*;

	logic [7:0] leftPos;
	logic [7:0] rightPos;
	logic [7:0] leftNext;
	logic [7:0] rightNext;
	logic       fire;

	// One step towards the top or bottom, held inside the limits
	function automatic logic [7:0] movePaddle(input logic [7:0] pos, input logic up,
		input logic down);
		logic [7:0] result;
		result = pos;
		if (up && pos > 8'(`PONG_PADDLE_MIN)) begin
			result = pos - 8'd1;
		end else if (down && pos < 8'(`PONG_PADDLE_MAX)) begin
			result = pos + 8'd1;
		end
		return result;
	endfunction

	assign cmdReady = !paddleOut.valid || paddleReady;
	assign fire = cmdIn.valid && cmdReady;

	always_comb begin
		leftNext = movePaddle(leftPos, cmdIn.cmd == cmdLeftUp, cmdIn.cmd == cmdLeftDown);
		rightNext = movePaddle(rightPos, cmdIn.cmd == cmdRightUp,
			cmdIn.cmd == cmdRightDown);
	end

	//////////////////////////////////////////////////////////////////////
	// Paddle state and output register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (resetBall) begin
			leftPos <= 8'(`PONG_PADDLE_HOME);
			rightPos <= 8'(`PONG_PADDLE_HOME);
			paddleOut.valid <= 1'b0;
		end else if (fire) begin
			leftPos <= leftNext;
			rightPos <= rightNext;
			// Every command goes on, ticks and launches too
			paddleOut <= '{
				valid: 1'b1,
				cmd: cmdIn.cmd,
				leftPos: leftNext,
				rightPos: rightNext
			};
		end else if (paddleReady) begin
			paddleOut.valid <= 1'b0;
		end
	end

endmodule

//--- ballStage.sv
`timescale 1ns/1ns
`include "pong_cfg.svh"

module ballStage (
	input  logic               CLK,
	input  logic               resetBall,
	input  pongPkg::paddleItem paddleIn,
	output logic               paddleReady,
	output pongPkg::ballItem   ballOut,
	input  logic               ballReady
);
	import pongPkg::*;

	typedef enum logic [1:0] {stIdle, stStep, stCheck, stFinish} stepState;

	stepState   state;
	stepState   stateNext;
	logic [7:0] ballX;
	logic [7:0] ballY;
	logic       dirX;
	logic       dirY;
	logic [2:0] speed;
	ballMode    mode;
	logic [2:0] stepCount;
	logic [7:0] padLeft;
	logic [7:0] padRight;

	logic [7:0] xNext;
	logic [7:0] yNext;
	logic       dirXNext;
	logic       dirYNext;
	logic [2:0] speedNext;
	ballMode    modeNext;
	logic [2:0] countNext;
	logic       emit;
	logic       pointL;
	logic       pointR;
	logic       serveLeft;
	logic       serveRight;

	logic       outFree;
	logic       fire;
	logic [7:0] curLeft;
	logic [7:0] curRight;
	logic [7:0] probeX;
	logic [7:0] probeY;
	logic       hitPaddle;
	logic       atWall;
	logic       atGoal;

	assign outFree = !ballOut.valid || ballReady;
	assign paddleReady = (state == stIdle) && outFree;
	assign fire = paddleIn.valid && paddleReady;

	// Incoming positions while idle, latched ones during a tick
	assign curLeft = (state == stIdle) ? paddleIn.leftPos : padLeft;
	assign curRight = (state == stIdle) ? paddleIn.rightPos : padRight;

	// dirX set means moving left, dirY set means moving up
	assign probeX = dirX ? ballX - 8'd1 : ballX + 8'd1;
	assign probeY = dirY ? ballY - 8'd1 : ballY + 8'd1;

	// Paddle covers rows pos-2 up to pos+1
	assign hitPaddle =
		(probeX == 8'(`PONG_LEFT_HIT_X) && probeY >= curLeft - 8'd2
			&& probeY < curLeft + 8'd2) ||
		(probeX == 8'(`PONG_RIGHT_HIT_X) && probeY >= curRight - 8'd2
			&& probeY < curRight + 8'd2);
	assign atWall = (ballY == 8'd0) || (ballY == 8'(`PONG_FIELD_H - 1));
	assign atGoal = (ballX == 8'd0) || (ballX == 8'(`PONG_FIELD_W - 1));

	//////////////////////////////////////////////////////////////////////
	// Motion FSM
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		stateNext = state;
		xNext = ballX;
		yNext = ballY;
		dirXNext = dirX;
		dirYNext = dirY;
		speedNext = speed;
		modeNext = mode;
		countNext = stepCount;
		emit = 1'b0;
		pointL = 1'b0;
		pointR = 1'b0;
		serveLeft = 1'b0;
		serveRight = 1'b0;
		case (state)
			stIdle: if (fire) begin
				if (paddleIn.cmd == cmdLaunch) begin
					modeNext = ballFlying;
					emit = 1'b1;
				end else if (paddleIn.cmd != cmdTick) begin
					emit = 1'b1;
				end else if (mode == ballHeldLeft) begin
					serveLeft = 1'b1;
					emit = 1'b1;
				end else if (mode == ballHeldRight) begin
					serveRight = 1'b1;
					emit = 1'b1;
				end else begin
					countNext = 3'd0;
					stateNext = stStep;
				end
			end
			stStep: begin
				if (stepCount < speed) begin
					xNext = probeX;
					yNext = probeY;
					stateNext = stCheck;
				end else begin
					stateNext = stFinish;
				end
			end
			stCheck: begin
				if (hitPaddle) begin
					dirXNext = !dirX;
					if (speed < 3'(`PONG_MAX_SPEED))
						speedNext = speed + 3'd1;
					if (atWall)
						dirYNext = !dirY;
					stateNext = stFinish;
				end else if (atGoal) begin
					stateNext = stFinish;
				end else if (atWall) begin
					// A wall bounce also ends the tick
					dirYNext = !dirY;
					stateNext = stFinish;
				end else begin
					countNext = stepCount + 3'd1;
					stateNext = stStep;
				end
			end
			stFinish: if (outFree) begin
				emit = 1'b1;
				stateNext = stIdle;
				if (ballX == 8'd0) begin
					pointR = 1'b1;
					serveLeft = 1'b1;
				end else if (ballX == 8'(`PONG_FIELD_W - 1)) begin
					pointL = 1'b1;
					serveRight = 1'b1;
				end
			end
			default: stateNext = stIdle;
		endcase

		// Serve puts the ball back on a paddle at speed 1
		if (serveLeft) begin
			xNext = 8'(`PONG_LEFT_SERVE_X);
			yNext = curLeft;
			dirXNext = 1'b0;
			dirYNext = 1'b0;
			speedNext = 3'd1;
			modeNext = ballHeldLeft;
		end else if (serveRight) begin
			xNext = 8'(`PONG_RIGHT_SERVE_X);
			yNext = curRight;
			dirXNext = 1'b1;
			dirYNext = 1'b0;
			speedNext = 3'd1;
			modeNext = ballHeldRight;
		end
	end

	always_ff @(posedge CLK) begin
		if (resetBall) begin
			state <= stIdle;
			ballX <= '0;
			ballY <= '0;
			dirX <= 1'b0;
			dirY <= 1'b0;
			speed <= '0;
			mode <= ballHeldLeft;
			stepCount <= '0;
			ballOut.valid <= 1'b0;
		end else begin
			state <= stateNext;
			ballX <= xNext;
			ballY <= yNext;
			dirX <= dirXNext;
			dirY <= dirYNext;
			speed <= speedNext;
			mode <= modeNext;
			stepCount <= countNext;
			if (emit) begin
				ballOut <= '{
					valid: 1'b1,
					pointLeft: pointL,
					pointRight: pointR,
					ballX: xNext,
					ballY: yNext,
					mode: modeNext,
					speed: speedNext,
					leftPos: curLeft,
					rightPos: curRight
				};
			end else if (ballReady) begin
				ballOut.valid <= 1'b0;
			end
		end
	end

	// Paddles stay fixed for the whole tick
	always_ff @(posedge CLK) begin
		if (fire) begin
			padLeft <= paddleIn.leftPos;
			padRight <= paddleIn.rightPos;
		end
	end

endmodule

//--- scoreStage.sv
`timescale 1ns/1ns
`include "pong_cfg.svh"

module scoreStage (
	input  logic               CLK,
	input  logic               resetBall,
	input  pongPkg::ballItem   ballIn,
	output logic               ballReady,
	output pongPkg::pongStatus status
);
	import pongPkg::*;

	// Status is a plain snapshot, so this stage never stalls
	assign ballReady = 1'b1;

	always_ff @(posedge CLK) begin
		if (resetBall) begin
			status <= '{
				done: 1'b0,
				scoreLeft: 4'd0,
				scoreRight: 4'd0,
				ballX: 8'd0,
				ballY: 8'd0,
				mode: ballHeldLeft,
				speed: 3'd0,
				leftPos: 8'(`PONG_PADDLE_HOME),
				rightPos: 8'(`PONG_PADDLE_HOME)
			};
		end else if (ballIn.valid) begin
			status <= '{
				done: 1'b1,
				scoreLeft: status.scoreLeft + {3'd0, ballIn.pointLeft},
				scoreRight: status.scoreRight + {3'd0, ballIn.pointRight},
				ballX: ballIn.ballX,
				ballY: ballIn.ballY,
				mode: ballIn.mode,
				speed: ballIn.speed,
				leftPos: ballIn.leftPos,
				rightPos: ballIn.rightPos
			};
		end else begin
			status.done <= 1'b0;
		end
	end

endmodule

//--- pongCore.sv
`timescale 1ns/1ns

module pongCore (
	input  logic        CLK,
	input  logic        resetBall,
	input  logic        PSEL,
	input  logic        PENABLE,
	input  logic        PWRITE,
	input  logic [3:0]  PADDR,
	input  logic [31:0] PWDATA,
	output logic        PREADY,
	output logic [31:0] PRDATA,
	output logic        PSLVERR
);
	import pongPkg::*;

	cmdItem    cmdBus;
	logic      cmdReady;
	paddleItem paddleBus;
	logic      paddleReady;
	ballItem   ballBus;
	logic      ballReady;
	pongStatus statusBus;

	//////////////////////////////////////////////////////////////////////
	// Register port, then paddle, ball and score stages
	//////////////////////////////////////////////////////////////////////
	pongApbPort port (
		.CLK(CLK),
		.resetBall(resetBall),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.PREADY(PREADY),
		.PRDATA(PRDATA),
		.PSLVERR(PSLVERR),
		.cmdOut(cmdBus),
		.cmdReady(cmdReady),
		.status(statusBus)
	);

	paddleStage paddles (
		.CLK(CLK),
		.resetBall(resetBall),
		.cmdIn(cmdBus),
		.cmdReady(cmdReady),
		.paddleOut(paddleBus),
		.paddleReady(paddleReady)
	);

	ballStage ball (
		.CLK(CLK),
		.resetBall(resetBall),
		.paddleIn(paddleBus),
		.paddleReady(paddleReady),
		.ballOut(ballBus),
		.ballReady(ballReady)
	);

	scoreStage score (
		.CLK(CLK),
		.resetBall(resetBall),
		.ballIn(ballBus),
		.ballReady(ballReady),
		.status(statusBus)
	);

endmodule

//--- pongTbModel.svh
`ifndef PONG_TB_MODEL_SVH
`define PONG_TB_MODEL_SVH

`include "pong_cfg.svh"

//////////////////////////////////////////////////////////////////////
// Game model state
//////////////////////////////////////////////////////////////////////
typedef struct packed {
	logic [7:0] leftPos;
	logic [7:0] rightPos;
	logic [7:0] ballX;
	logic [7:0] ballY;
	logic       dirX;
	logic       dirY;
	logic [2:0] speed;
	ballMode    mode;
	logic [3:0] scoreLeft;
	logic [3:0] scoreRight;
} modelState;

function automatic modelState resetModel();
	modelState s;
	s = '0;
	s.mode = ballHeldLeft;
	s.leftPos = `PONG_PADDLE_HOME;
	s.rightPos = `PONG_PADDLE_HOME;
	return s;
endfunction

// Ball placed next to a paddle, still held
function automatic modelState serveBall(input modelState s, input logic fromRight);
	modelState n;
	n = s;
	n.ballX = fromRight ? `PONG_RIGHT_SERVE_X : `PONG_LEFT_SERVE_X;
	n.ballY = fromRight ? s.rightPos : s.leftPos;
	n.dirX = fromRight;
	n.dirY = 1'b0;
	n.speed = 3'd1;
	n.mode = fromRight ? ballHeldRight : ballHeldLeft;
	return n;
endfunction

function automatic modelState pongModel(input modelState s, input logic tick,
	input logic [7:0] key);
	modelState n;
	int steps;
	int nx;
	int ny;
	int lp;
	int rp;
	logic hit;
	logic wall;
	logic ended;
	n = s;
	if (!tick) begin
		case (key)
			`PONG_KEY_LEFT_UP:    if (n.leftPos > `PONG_PADDLE_MIN) n.leftPos = n.leftPos - 8'd1;
			`PONG_KEY_LEFT_DOWN:  if (n.leftPos < `PONG_PADDLE_MAX) n.leftPos = n.leftPos + 8'd1;
			`PONG_KEY_RIGHT_UP:   if (n.rightPos > `PONG_PADDLE_MIN) n.rightPos = n.rightPos - 8'd1;
			`PONG_KEY_RIGHT_DOWN: if (n.rightPos < `PONG_PADDLE_MAX) n.rightPos = n.rightPos + 8'd1;
			`PONG_KEY_LAUNCH:     n.mode = ballFlying;
			default:              ;
		endcase
	end else if (n.mode == ballHeldLeft) begin
		n = serveBall(n, 1'b0);
	end else if (n.mode == ballHeldRight) begin
		n = serveBall(n, 1'b1);
	end else begin
		steps = 0;
		ended = 1'b0;
		lp = n.leftPos;
		rp = n.rightPos;
		while (!ended && steps < n.speed) begin
			n.ballX = n.dirX ? n.ballX - 8'd1 : n.ballX + 8'd1;
			n.ballY = n.dirY ? n.ballY - 8'd1 : n.ballY + 8'd1;
			// Cell the ball would enter next
			nx = n.dirX ? int'(n.ballX) - 1 : int'(n.ballX) + 1;
			ny = n.dirY ? int'(n.ballY) - 1 : int'(n.ballY) + 1;
			hit = (nx == `PONG_LEFT_HIT_X && ny >= lp - 2 && ny <= lp + 1) ||
				(nx == `PONG_RIGHT_HIT_X && ny >= rp - 2 && ny <= rp + 1);
			wall = (n.ballY == 8'd0) || (n.ballY == `PONG_FIELD_H - 1);
			if (hit) begin
				n.dirX = !n.dirX;
				if (n.speed < `PONG_MAX_SPEED)
					n.speed = n.speed + 3'd1;
				if (wall)
					n.dirY = !n.dirY;
				ended = 1'b1;
			end else if (n.ballX == 8'd0 || n.ballX == `PONG_FIELD_W - 1) begin
				ended = 1'b1;
			end else if (wall) begin
				n.dirY = !n.dirY;
				ended = 1'b1;
			end else begin
				steps++;
			end
		end
		if (n.ballX == 8'd0) begin
			n.scoreRight = n.scoreRight + 4'd1;
			n = serveBall(n, 1'b0);
		end else if (n.ballX == `PONG_FIELD_W - 1) begin
			n.scoreLeft = n.scoreLeft + 4'd1;
			n = serveBall(n, 1'b1);
		end
	end
	return n;
endfunction

// Register images, busy clear once idle
function automatic logic [31:0] expectedPos(input modelState s);
	return {s.rightPos, s.leftPos, s.ballY, s.ballX};
endfunction

function automatic logic [31:0] expectedState(input modelState s);
	return {15'd0, 1'b0, 1'b0, s.speed, 2'b00, s.mode, s.scoreRight, s.scoreLeft};
endfunction

`endif

//--- pongTb.sv
`timescale 1ns/1ns
`include "pong_cfg.svh"

module pongTb;
	import pongPkg::*;
	`include "pongTbModel.svh"

	// Worst case command count per test
	localparam int numCmds = 43 + 22 + 74 + 220 + 3;
	localparam int cycleLimit = 20 * numCmds * 14;

	logic        CLK;
	logic        resetBall;
	logic        PSEL;
	logic        PENABLE;
	logic        PWRITE;
	logic [3:0]  PADDR;
	logic [31:0] PWDATA;
	logic        PREADY;
	logic [31:0] PRDATA;
	logic        PSLVERR;

	modelState   model;
	logic [31:0] posWord;
	logic [31:0] stateWord;
	int          errorCount = 0;
	int          testStartErrors = 0;
	int          testsRun = 0;
	int          checksRequested = 0;
	int          checksDone = 0;
	int          cycleCount = 0;
	int          seed;

	pongCore dut (
		.CLK(CLK),
		.resetBall(resetBall),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.PREADY(PREADY),
		.PRDATA(PRDATA),
		.PSLVERR(PSLVERR)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
			$display("Regression failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// APB driver
	//////////////////////////////////////////////////////////////////////
	task automatic apbAccess(input logic write, input logic [3:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		@(posedge CLK);
		#5;
		PSEL = 1'b1;
		PENABLE = 1'b0;
		PWRITE = write;
		PADDR = addr;
		PWDATA = data;
		@(posedge CLK);
		#5;
		PENABLE = 1'b1;
		// Sampled mid cycle, away from the edges
		#10;
		while (!PREADY) begin
			@(posedge CLK);
			#15;
		end
		rdata = PRDATA;
		err = PSLVERR;
		@(posedge CLK);
		#5;
		PSEL = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic readBack();
		logic err;
		apbAccess(1'b0, `PONG_REG_STATE, 32'd0, stateWord, err);
		apbAccess(1'b0, `PONG_REG_POS, 32'd0, posWord, err);
	endtask

	task automatic waitIdle();
		logic [31:0] rdata;
		logic err;
		do begin
			apbAccess(1'b0, `PONG_REG_STATE, 32'd0, rdata, err);
		end while (rdata[16]);
	endtask

	task automatic requestCompare();
		checksRequested++;
		wait (checksDone == checksRequested);
	endtask

	task automatic sendCommand(input logic tick, input logic [7:0] key);
		logic [31:0] rdata;
		logic err;
		apbAccess(1'b1, tick ? `PONG_REG_TICK : `PONG_REG_KEY, {24'd0, key}, rdata, err);
		assert (!err) else begin
			$display("ERR %0t: command write got PSLVERR", $time);
			errorCount++;
		end
		model = pongModel(model, tick, key);
		waitIdle();
		readBack();
		requestCompare();
	endtask

	task automatic finishTest(input int num, input string name);
		$display("Test %0d %s: %0d errors", num, name, errorCount - testStartErrors);
		testStartErrors = errorCount;
		testsRun++;
	endtask

	// Read-back against the model
	initial begin
		forever begin
			wait (checksRequested != checksDone);
			assert (posWord == expectedPos(model)) else begin
				$display("ERR %0t: POS read %h, expected %h", $time, posWord, expectedPos(model));
				errorCount++;
			end
			assert (stateWord == expectedState(model)) else begin
				$display("ERR %0t: STATE read %h, expected %h", $time, stateWord,
					expectedState(model));
				errorCount++;
			end
			checksDone++;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] rdata;
		logic err;
		logic seen;
		logic [7:0] prevX;
		logic [3:0] pick;
		seed = 37504;
		resetBall = 1'b1;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = 4'd0;
		PWDATA = 32'd0;
		model = resetModel();
		repeat (2) @(posedge CLK);
		#5;
		resetBall = 1'b0;

		readBack();
		requestCompare();
		finishTest(1, "reset values");

		// Left paddle hits the top limit, right one the bottom limit
		repeat (10) sendCommand(1'b0, `PONG_KEY_LEFT_UP);
		repeat (10) sendCommand(1'b0, `PONG_KEY_LEFT_DOWN);
		repeat (10) sendCommand(1'b0, `PONG_KEY_RIGHT_DOWN);
		repeat (10) sendCommand(1'b0, `PONG_KEY_RIGHT_UP);
		sendCommand(1'b0, 8'h41);
		sendCommand(1'b0, 8'h00);
		sendCommand(1'b0, 8'hFF);
		finishTest(2, "paddle moves and clamping");

		sendCommand(1'b1, 8'h00);
		sendCommand(1'b0, `PONG_KEY_LAUNCH);
		repeat (20) sendCommand(1'b1, 8'h00);
		finishTest(3, "held ball and launch");

		// Ball meets column 61 near row 2, so park the right paddle at 3
		repeat (3) sendCommand(1'b0, `PONG_KEY_RIGHT_UP);
		seen = 1'b0;
		for (int i = 0; i < 70 && !seen; i++) begin
			sendCommand(1'b1, 8'h00);
			if (stateWord[14:12] > 3'd1)
				seen = 1'b1;
		end
		assert (seen && stateWord[14:12] == 3'd2) else begin
			$display("ERR %0t: speed %0d after paddle bounce, expected 2", $time,
				stateWord[14:12]);
			errorCount++;
		end
		prevX = posWord[7:0];
		sendCommand(1'b1, 8'h00);
		assert (posWord[7:0] < prevX) else begin
			$display("ERR %0t: ball x %0d did not move back from %0d", $time,
				posWord[7:0], prevX);
			errorCount++;
		end
		finishTest(4, "paddle bounce");

		seen = 1'b0;
		for (int i = 0; i < 100 && !seen; i++) begin
			sendCommand(1'b1, 8'h00);
			if (stateWord[7:0] != 8'd0)
				seen = 1'b1;
		end
		assert (seen) else begin
			$display("No point was scored within 100 ticks");
			errorCount++;
		end
		repeat (120) begin
			pick = 4'($random(seed));
			case (pick)
				4'd0:    sendCommand(1'b0, `PONG_KEY_LEFT_UP);
				4'd1:    sendCommand(1'b0, `PONG_KEY_LEFT_DOWN);
				4'd2:    sendCommand(1'b0, `PONG_KEY_RIGHT_UP);
				4'd3:    sendCommand(1'b0, `PONG_KEY_RIGHT_DOWN);
				4'd4:    sendCommand(1'b0, `PONG_KEY_LAUNCH);
				4'd15:   sendCommand(1'b0, 8'h41);
				default: sendCommand(1'b1, 8'h00);
			endcase
		end
		finishTest(5, "scoring and random play");

		// PADDR has four bits, so unmapped offsets in range stand in
		apbAccess(1'b0, 4'h2, 32'd0, rdata, err);
		assert (err) else begin
			$display("Read at offset 0x2 completed without PSLVERR");
			errorCount++;
		end
		apbAccess(1'b1, `PONG_REG_POS, {24'd0, `PONG_KEY_LEFT_UP}, rdata, err);
		assert (err) else begin
			$display("Write at offset 0x8 completed without PSLVERR");
			errorCount++;
		end
		apbAccess(1'b1, 4'hE, 32'd0, rdata, err);
		assert (err) else begin
			$display("Write at offset 0xE completed without PSLVERR");
			errorCount++;
		end
		waitIdle();
		readBack();
		requestCompare();
		finishTest(6, "bad address");

		$display("Tests %0d, checks %0d, errors %0d", testsRun, checksDone, errorCount);
		if (errorCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+.
pongPkg.sv
pongApbPort.sv
paddleStage.sv
ballStage.sv
scoreStage.sv
pongCore.sv
pongTb.sv

//--- Bender.yml
package:
  name: pong

sources:
  - include_dirs:
      - .
    files:
      - pongPkg.sv
      - pongApbPort.sv
      - paddleStage.sv
      - ballStage.sv
      - scoreStage.sv
      - pongCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - pongTb.sv
